//--- Makefile
# Verilator build and run of the control block testbench

TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_chimera_ctrl
FILELIST  ?= chimera_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

FAIL_MSG := TEST RESULT: FAIL
PASS_MSG := TEST RESULT: PASS

.DEFAULT_GOAL := help

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), result taken from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# The log decides the result, so the run status itself is ignored here
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- chimera_ctrl.f
+incdir+rtl
rtl/chimera_ctrl_pkg.sv
rtl/chimera_reg_demux.sv
rtl/chimera_reg_top.sv
rtl/snitch_bootrom.sv
rtl/cluster_clk_gate.sv
rtl/chimera_ctrl_top.sv
sim/tb_chimera_ctrl.sv

//--- rtl/chimera_ctrl_consts.svh
// Shared widths, address map and register offsets of the control block.
// Included by the package and by every module that sizes or decodes
// bus fields.

`ifndef CHIMERA_CTRL_CONSTS_SVH
`define CHIMERA_CTRL_CONSTS_SVH

// Number of gated compute clusters
`define CHIMERA_NUM_CLUSTERS 5

// Register bus widths
`define CHIMERA_ADDR_W 32
`define CHIMERA_DATA_W 32

// Upper address bits select a 4 KiB region
`define CHIMERA_REGION_W 20
`define CHIMERA_ROM_REGION 20'h30000
`define CHIMERA_REG_REGION 20'h30001

// Word offsets inside the register window
`define CHIMERA_REG_CLK_GATE 0
`define CHIMERA_REG_NUM_CLU 1

// Stored boot ROM words, the rest of the window reads zero
`define CHIMERA_ROM_WORDS 16

`endif

//--- rtl/chimera_ctrl_pkg.sv
// Types shared by the control block modules.
// Referenced by scoped names from the decoder and the two bus targets.

`default_nettype none

`include "chimera_ctrl_consts.svh"

package chimera_ctrl_pkg;

   // Register view of a bus address
   typedef struct packed {
      logic [`CHIMERA_REGION_W-1:0]                  region;
      logic [`CHIMERA_ADDR_W-`CHIMERA_REGION_W-3:0] reg_off;
      logic [1:0]                                    byte_off;
   } reg_view_t;

   // Same bits seen by the boot ROM as a word index
   typedef struct packed {
      logic [`CHIMERA_REGION_W-1:0]                  region;
      logic [`CHIMERA_ADDR_W-`CHIMERA_REGION_W-3:0] rom_idx;
      logic [1:0]                                    byte_off;
   } rom_view_t;

   typedef union packed {
      reg_view_t regs;
      rom_view_t rom;
   } reg_addr_u;

   // One clock-gate bit per cluster, 1 stops the clock
   typedef logic [`CHIMERA_NUM_CLUSTERS-1:0] cluster_mask_t;

endpackage

`default_nettype wire

//--- rtl/chimera_ctrl_top.sv
// Top level of the SoC-side control block.
// One register bus reaches the boot ROM and the control registers,
// whose gate bits drive one clock gate per cluster.

`timescale 1ns/100ps
`default_nettype none

`include "chimera_ctrl_consts.svh"

module chimera_ctrl_top (
   input  logic                            soc_clk_i,
   input  logic                            clu_clk_i,
   input  logic                            reset_i,
   // Register bus
   input  logic                            reg_valid_i,
   input  logic                            reg_write_i,
   input  logic [`CHIMERA_ADDR_W-1:0]      reg_addr_i,
   input  logic [`CHIMERA_DATA_W-1:0]      reg_wdata_i,
   output logic                            reg_ready_o,
   output logic                            reg_error_o,
   output logic [`CHIMERA_DATA_W-1:0]      reg_rdata_o,
   // Gated cluster clocks
   output chimera_ctrl_pkg::cluster_mask_t clu_clk_o
);

   logic                            rom_sel;
   logic                            rom_ready;
   logic                            rom_error;
   logic [`CHIMERA_DATA_W-1:0]      rom_rdata;
   logic                            regs_sel;
   logic                            regs_ready;
   logic                            regs_error;
   logic [`CHIMERA_DATA_W-1:0]      regs_rdata;
   chimera_ctrl_pkg::cluster_mask_t clk_gate_en;

   // ---------------------------------------------------------
   // Bus decode and targets
   // ---------------------------------------------------------
   chimera_reg_demux i_reg_demux (
      .soc_clk_i   (soc_clk_i),
      .reset_i     (reset_i),
      .reg_valid_i (reg_valid_i),
      .reg_addr_i  (reg_addr_i),
      .reg_ready_o (reg_ready_o),
      .reg_error_o (reg_error_o),
      .reg_rdata_o (reg_rdata_o),
      .rom_sel_o   (rom_sel),
      .regs_sel_o  (regs_sel),
      .rom_ready_i (rom_ready),
      .rom_error_i (rom_error),
      .rom_rdata_i (rom_rdata),
      .regs_ready_i(regs_ready),
      .regs_error_i(regs_error),
      .regs_rdata_i(regs_rdata)
   );

   chimera_reg_top i_reg_top (
      .soc_clk_i    (soc_clk_i),
      .reset_i      (reset_i),
      .sel_i        (regs_sel),
      .write_i      (reg_write_i),
      .addr_i       (reg_addr_i),
      .wdata_i      (reg_wdata_i),
      .ready_o      (regs_ready),
      .error_o      (regs_error),
      .rdata_o      (regs_rdata),
      .clk_gate_en_o(clk_gate_en)
   );

   snitch_bootrom i_snitch_bootrom (
      .soc_clk_i(soc_clk_i),
      .reset_i  (reset_i),
      .sel_i    (rom_sel),
      .write_i  (reg_write_i),
      .addr_i   (reg_addr_i),
      .ready_o  (rom_ready),
      .error_o  (rom_error),
      .rdata_o  (rom_rdata)
   );

   // ---------------------------------------------------------
   // Cluster clock gates
   // ---------------------------------------------------------
   for (genvar clu = 0; clu < `CHIMERA_NUM_CLUSTERS; clu++) begin : gen_clk_gates
      cluster_clk_gate i_cluster_clk_gate (
         .clu_clk_i(clu_clk_i),
         .reset_i  (reset_i),
         .gate_en_i(clk_gate_en[clu]),
         .clk_o    (clu_clk_o[clu])
      );
   end

endmodule

`default_nettype wire

//--- rtl/chimera_reg_demux.sv
// Region decoder of the register bus.
// Steers each request to the boot ROM or the control registers by the
// region field and merges the responses. Unmapped regions error at once.

`timescale 1ns/100ps
`default_nettype none

`include "chimera_ctrl_consts.svh"

module chimera_reg_demux (
   input  logic                         soc_clk_i,
   input  logic                         reset_i,
   // Upstream bus
   input  logic                         reg_valid_i,
   input  chimera_ctrl_pkg::reg_addr_u  reg_addr_i,
   output logic                         reg_ready_o,
   output logic                         reg_error_o,
   output logic [`CHIMERA_DATA_W-1:0]   reg_rdata_o,
   // Target selects
   output logic                         rom_sel_o,
   output logic                         regs_sel_o,
   // Target responses
   input  logic                         rom_ready_i,
   input  logic                         rom_error_i,
   input  logic [`CHIMERA_DATA_W-1:0]   rom_rdata_i,
   input  logic                         regs_ready_i,
   input  logic                         regs_error_i,
   input  logic [`CHIMERA_DATA_W-1:0]   regs_rdata_i
);

   logic rom_hit;
   logic regs_hit;

   // Only the region field takes part in the decode
   assign rom_hit  = (reg_addr_i.regs.region == `CHIMERA_ROM_REGION);
   assign regs_hit = (reg_addr_i.regs.region == `CHIMERA_REG_REGION);

   assign rom_sel_o  = reg_valid_i & rom_hit;
   assign regs_sel_o = reg_valid_i & regs_hit;

   // ---------------------------------------------------------
   // Response merge
   // ---------------------------------------------------------
   always_comb begin
      if (rom_hit) begin
         reg_ready_o = rom_ready_i;
         reg_error_o = rom_error_i;
         reg_rdata_o = rom_rdata_i;
      end else if (regs_hit) begin
         reg_ready_o = regs_ready_i;
         reg_error_o = regs_error_i;
         reg_rdata_o = regs_rdata_i;
      end else begin
         // Nothing behind this region
         reg_ready_o = reg_valid_i;
         reg_error_o = reg_valid_i;
         reg_rdata_o = '0;
      end
   end

   // Targets answer only to a live request, including the delayed ROM
   a_ready_needs_valid : assert property (
      @(posedge soc_clk_i) disable iff (reset_i) reg_ready_o |-> reg_valid_i
   );

endmodule

`default_nettype wire

//--- rtl/chimera_reg_top.sv
// Control register file of the SoC-side block.
// Holds the per-cluster clock-gate bits and a read-only cluster count.
// Every access is answered combinationally in its own cycle.

`timescale 1ns/100ps
`default_nettype none

`include "chimera_ctrl_consts.svh"

module chimera_reg_top (
   input  logic                            soc_clk_i,
   input  logic                            reset_i,
   // Request from the decoder
   input  logic                            sel_i,
   input  logic                            write_i,
   input  chimera_ctrl_pkg::reg_addr_u     addr_i,
   input  logic [`CHIMERA_DATA_W-1:0]      wdata_i,
   // Response
   output logic                            ready_o,
   output logic                            error_o,
   output logic [`CHIMERA_DATA_W-1:0]      rdata_o,
   // Gate bits towards the cluster clock gates
   output chimera_ctrl_pkg::cluster_mask_t clk_gate_en_o
);

   localparam int unsigned PadW = `CHIMERA_DATA_W - `CHIMERA_NUM_CLUSTERS;

   chimera_ctrl_pkg::cluster_mask_t clk_gate_q;
   logic                            gate_wr;
   logic                            access_err;

   // ---------------------------------------------------------
   // Gate register
   // ---------------------------------------------------------
   assign gate_wr = sel_i & write_i & (addr_i.regs.reg_off == `CHIMERA_REG_CLK_GATE);

   always_ff @(posedge soc_clk_i) begin
      if (reset_i) begin
         clk_gate_q <= '0;
      end else if (gate_wr) begin
         // Upper write bits are dropped
         clk_gate_q <= wdata_i[`CHIMERA_NUM_CLUSTERS-1:0];
      end
   end

   assign clk_gate_en_o = clk_gate_q;

   // ---------------------------------------------------------
   // Read mux and error decode
   // ---------------------------------------------------------
   always_comb begin
      rdata_o    = '0;
      access_err = 1'b0;
      case (addr_i.regs.reg_off)
         `CHIMERA_REG_CLK_GATE: begin
            rdata_o = {{PadW{1'b0}}, clk_gate_q};
         end
         `CHIMERA_REG_NUM_CLU: begin
            // Read-only, a write is refused
            if (write_i) begin
               access_err = 1'b1;
            end else begin
               rdata_o = `CHIMERA_DATA_W'(`CHIMERA_NUM_CLUSTERS);
            end
         end
         default: begin
            access_err = 1'b1;
         end
      endcase
      if (!sel_i) begin
         rdata_o = '0;
      end
   end

   assign ready_o = sel_i;
   assign error_o = sel_i & access_err;

endmodule

`default_nettype wire

//--- rtl/cluster_clk_gate.sv
// Glitch-free clock gate for one compute cluster.
// The gate bit crosses into the cluster clock domain through two flops
// and is latched while the clock is low before it masks the clock.

`timescale 1ns/100ps
`default_nettype none

module cluster_clk_gate (
   input  logic clu_clk_i,
   input  logic reset_i,
   // 1 stops the cluster clock
   input  logic gate_en_i,
   output logic clk_o
);

   logic gate_meta_q;
   logic gate_sync_q;
   logic clk_en_latch;

   // ---------------------------------------------------------
   // Synchronizer into the cluster domain
   // ---------------------------------------------------------
   always_ff @(posedge clu_clk_i) begin
      if (reset_i) begin
         gate_meta_q <= 1'b0;
         gate_sync_q <= 1'b0;
      end else begin
         gate_meta_q <= gate_en_i;
         gate_sync_q <= gate_meta_q;
      end
   end

   // ---------------------------------------------------------
   // Latch and mask
   // ---------------------------------------------------------
   // Transparent only in the low phase, so the enable is stable while high
   always_latch begin
      if (!clu_clk_i) begin
         clk_en_latch = ~gate_sync_q;
      end
   end

   assign clk_o = clu_clk_i & clk_en_latch;

   // High phase follows the enable from the previous cycle
   a_gated_stays_low : assert property (
      @(negedge clu_clk_i) disable iff (reset_i) $past(gate_sync_q) |-> !clk_o
   );

endmodule

`default_nettype wire

//--- rtl/snitch_bootrom.sv
// Cluster boot stub behind a memory-style port.
// A new select is captured on the clock edge and answered one cycle
// later; writes are refused with an error as the ROM is read-only.

`timescale 1ns/100ps
`default_nettype none

`include "chimera_ctrl_consts.svh"

module snitch_bootrom (
   input  logic                        soc_clk_i,
   input  logic                        reset_i,
   // Request from the decoder
   input  logic                        sel_i,
   input  logic                        write_i,
   input  chimera_ctrl_pkg::reg_addr_u addr_i,
   // Response one cycle after capture
   output logic                        ready_o,
   output logic                        error_o,
   output logic [`CHIMERA_DATA_W-1:0]  rdata_o
);

   localparam int unsigned IdxW = $clog2(`CHIMERA_ROM_WORDS);

   // Read hart id, wfi, jump back to the wfi
   localparam logic [`CHIMERA_DATA_W-1:0] RomTable [`CHIMERA_ROM_WORDS] = '{
      32'hF1402573, 32'h10500073, 32'hFFDFF06F, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000
   };

   logic [`CHIMERA_DATA_W-1:0] rom_data;
   logic [`CHIMERA_DATA_W-1:0] data_q;
   logic                       new_req;
   logic                       pend_q;
   logic                       we_q;

   // ---------------------------------------------------------
   // Table lookup
   // ---------------------------------------------------------
   always_comb begin
      // Indices past the table still inside the window read zero
      if (addr_i.rom.rom_idx < `CHIMERA_ROM_WORDS) begin
         rom_data = RomTable[addr_i.rom.rom_idx[IdxW-1:0]];
      end else begin
         rom_data = '0;
      end
   end

   // ---------------------------------------------------------
   // One-cycle response
   // ---------------------------------------------------------
   // The held request is not taken again while its answer is out
   assign new_req = sel_i & ~pend_q;

   always_ff @(posedge soc_clk_i) begin
      if (reset_i) begin
         pend_q <= 1'b0;
         we_q   <= 1'b0;
      end else begin
         pend_q <= new_req;
         if (new_req) begin
            we_q <= write_i;
         end
      end
   end

   always_ff @(posedge soc_clk_i) begin
      if (new_req) begin
         data_q <= rom_data;
      end
   end

   assign ready_o = pend_q;
   assign error_o = pend_q & we_q;
   assign rdata_o = (pend_q && !we_q) ? data_q : '0;

   // The answer goes to the captured request, still held unchanged
   a_ready_after_req : assert property (
      @(posedge soc_clk_i) disable iff (reset_i)
         ready_o |-> sel_i && $stable(addr_i) && $stable(write_i)
   );

endmodule

`default_nettype wire

//--- sim/tb_chimera_ctrl.sv
// Directed testbench of the SoC-side control block.
// Drives the register bus into the register window, the boot ROM and an
// unmapped region, and counts edges on the gated cluster clocks.

`timescale 1ns/100ps
`default_nettype none

module tb_chimera_ctrl;

   localparam int          NumClusters   = 5;
   localparam int          RomWords      = 16;
   localparam logic [19:0] RomRegion     = 20'h30000;
   localparam logic [19:0] RegRegion     = 20'h30001;
   localparam logic [19:0] BadRegion     = 20'h40000;
   localparam int          GateOff       = 0;
   localparam int          CountOff      = 1;
   localparam int          BadOff        = 7;
   localparam int          ResetCycles   = 16;
   localparam int          ReadyLimit    = 4;
   localparam int          GateSettle    = 4;
   localparam int          WindowCycles  = 8;
   // Rough upper bound of the whole test sequence in cycles
   localparam int          TestCycles    = 2000;
   localparam int          TimeoutCycles = 2 * TestCycles;
   localparam logic [31:0] GateMask      = (32'd1 << NumClusters) - 32'd1;
   localparam logic [15:0] LfsrSeed      = 16'd18253;
   localparam logic [15:0] LfsrTaps      = 16'hB400;

   // Boot stub of hart id read, wfi and jump back to the wfi
   localparam logic [31:0] RomImage [RomWords] = '{
      32'hF1402573, 32'h10500073, 32'hFFDFF06F, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000
   };

   logic                   clk = 1'b0;
   logic                   reset_i;
   logic                   reg_valid_i;
   logic                   reg_write_i;
   logic [31:0]            reg_addr_i;
   logic [31:0]            reg_wdata_i;
   logic                   reg_ready_o;
   logic                   reg_error_o;
   logic [31:0]            reg_rdata_o;
   logic [NumClusters-1:0] clu_clk_o;

   logic [NumClusters-1:0] clu_clk_prev = '0;
   int unsigned            clu_edges [NumClusters] = '{default: 0};
   int                     cycle_count = 0;
   int                     error_count;
   logic [15:0]            lfsr_state;
   string                  test_name;

   chimera_ctrl_top i_dut (
      .soc_clk_i  (clk),
      .clu_clk_i  (clk),
      .reset_i    (reset_i),
      .reg_valid_i(reg_valid_i),
      .reg_write_i(reg_write_i),
      .reg_addr_i (reg_addr_i),
      .reg_wdata_i(reg_wdata_i),
      .reg_ready_o(reg_ready_o),
      .reg_error_o(reg_error_o),
      .reg_rdata_o(reg_rdata_o),
      .clu_clk_o  (clu_clk_o)
   );

   always #5 clk = ~clk;

   // Free-running rising edge counters of the gated clocks
   always @(clu_clk_o) begin
      for (int k = 0; k < NumClusters; k++) begin
         if (clu_clk_o[k] && !clu_clk_prev[k]) begin
            clu_edges[k] = clu_edges[k] + 1;
         end
      end
      clu_clk_prev = clu_clk_o;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TimeoutCycles) begin
         $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Simulation stopped by the cycle limit");
      end
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   task automatic check_value(input string signal, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         error_count++;
         $display("FAILED at %0t in %s: %s is 0x%08h, expected 0x%08h",
                  $time, test_name, signal, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Simulation stopped at the first mismatch");
      end
   endtask

   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic [15:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ LfsrTaps;
      end
      return next;
   endfunction

   // One LFSR step per bit taken
   task automatic random_bits(input int nbits, output logic [31:0] value);
      value = '0;
      for (int b = 0; b < nbits; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value[b]   = lfsr_state[0];
      end
   endtask

   function automatic logic [31:0] window_addr(input logic [19:0] region,
                                               input int unsigned word);
      return {region, word[9:0], 2'b00};
   endfunction

   // One bus request; latency counts the cycles with ready still low
   task automatic bus_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input int exp_latency,
                             output logic [31:0] rdata, output logic error);
      int waited;
      waited = 0;
      @(posedge clk);
      #1;
      reg_valid_i = 1'b1;
      reg_write_i = write;
      reg_addr_i  = addr;
      reg_wdata_i = wdata;
      @(negedge clk);
      while (!reg_ready_o && waited < ReadyLimit) begin
         waited++;
         @(negedge clk);
      end
      if (!reg_ready_o) begin
         $display("No ready from the DUT within %0d cycles of the request to 0x%08h",
                  ReadyLimit, addr);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Bus request was never answered");
      end
      rdata = reg_rdata_o;
      error = reg_error_o;
      check_value("reg_ready_o latency", waited, exp_latency);
      @(posedge clk);
      #1;
      reg_valid_i = 1'b0;
      reg_write_i = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      // Ready stays low once the request is gone
      @(negedge clk);
      check_value("reg_ready_o idle", 32'(reg_ready_o), 32'd0);
   endtask

   task automatic read_check(input logic [31:0] addr, input logic [31:0] exp_rdata,
                             input logic exp_error, input int exp_latency);
      logic [31:0] rdata;
      logic        error;
      bus_access(1'b0, addr, '0, exp_latency, rdata, error);
      check_value("reg_error_o", 32'(error), 32'(exp_error));
      check_value("reg_rdata_o", rdata, exp_rdata);
   endtask

   task automatic write_check(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic exp_error, input int exp_latency);
      logic [31:0] rdata;
      logic        error;
      bus_access(1'b1, addr, wdata, exp_latency, rdata, error);
      check_value("reg_error_o", 32'(error), 32'(exp_error));
      if (exp_error) begin
         check_value("reg_rdata_o", rdata, '0);
      end
   endtask

   // Counts edges per cluster over a fixed window and compares with the gate bits
   task automatic measure_clock_edges(input logic [NumClusters-1:0] gate_bits);
      int unsigned start_cnt [NumClusters];
      int unsigned seen;
      @(posedge clk);
      #1;
      for (int k = 0; k < NumClusters; k++) begin
         start_cnt[k] = clu_edges[k];
      end
      repeat (WindowCycles) @(posedge clk);
      #1;
      for (int k = 0; k < NumClusters; k++) begin
         seen = clu_edges[k] - start_cnt[k];
         check_value($sformatf("clu_clk_o[%0d] rising edges", k), seen,
                     gate_bits[k] ? 32'd0 : 32'(WindowCycles));
      end
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------
   task automatic test_after_reset();
      test_name = "after reset";
      read_check(window_addr(RegRegion, GateOff), 32'd0, 1'b0, 0);
      read_check(window_addr(RegRegion, CountOff), 32'(NumClusters), 1'b0, 0);
      measure_clock_edges('0);
   endtask

   task automatic test_gate_readback();
      logic [31:0] value;
      test_name = "gate write and read-back";
      repeat (10) begin
         random_bits(32, value);
         write_check(window_addr(RegRegion, GateOff), value, 1'b0, 0);
         read_check(window_addr(RegRegion, GateOff), value & GateMask, 1'b0, 0);
      end
   endtask

   task automatic test_clock_gating();
      logic [31:0] pattern;
      test_name = "gating per cluster";
      repeat (6) begin
         random_bits(NumClusters, pattern);
         write_check(window_addr(RegRegion, GateOff), pattern, 1'b0, 0);
         repeat (GateSettle) @(posedge clk);
         measure_clock_edges(pattern[NumClusters-1:0]);
      end
      // All clocks back on
      write_check(window_addr(RegRegion, GateOff), 32'd0, 1'b0, 0);
      repeat (GateSettle) @(posedge clk);
      measure_clock_edges('0);
   endtask

   task automatic test_rom_reads();
      test_name = "boot ROM reads";
      for (int i = 0; i < RomWords; i++) begin
         read_check(window_addr(RomRegion, i), RomImage[i], 1'b0, 1);
      end
      read_check(window_addr(RomRegion, 16), 32'd0, 1'b0, 1);
      read_check(window_addr(RomRegion, 1000), 32'd0, 1'b0, 1);
   endtask

   task automatic test_error_responses();
      logic [31:0] keep;
      test_name = "error responses";
      write_check(window_addr(RomRegion, 1), 32'hDEADBEEF, 1'b1, 1);
      read_check(window_addr(RomRegion, 1), RomImage[1], 1'b0, 1);
      random_bits(NumClusters, keep);
      write_check(window_addr(RegRegion, GateOff), keep, 1'b0, 0);
      write_check(window_addr(RegRegion, CountOff), ~keep, 1'b1, 0);
      read_check(window_addr(RegRegion, BadOff), 32'd0, 1'b1, 0);
      write_check(window_addr(RegRegion, BadOff), ~keep, 1'b1, 0);
      read_check(window_addr(BadRegion, GateOff), 32'd0, 1'b1, 0);
      write_check(window_addr(BadRegion, GateOff), ~keep, 1'b1, 0);
      // None of the refused writes may reach the gate register
      read_check(window_addr(RegRegion, GateOff), keep & GateMask, 1'b0, 0);
      write_check(window_addr(RegRegion, GateOff), 32'd0, 1'b0, 0);
   endtask

   initial begin
      reset_i     = 1'b1;
      reg_valid_i = 1'b0;
      reg_write_i = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      error_count = 0;
      lfsr_state  = LfsrSeed;
      test_name   = "reset";
      repeat (ResetCycles) @(posedge clk);
      #1;
      reset_i = 1'b0;

      test_after_reset();
      test_gate_readback();
      test_clock_gating();
      test_rom_reads();
      test_error_responses();

      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
